// ==== hw/isa_pkg.sv ====
//**************************************************************************
// Instruction set definitions for the four-stage core: data and
// instruction types, field positions inside a 16-bit instruction and the
// opcode values. Referenced by scoped name from the stages and the bench.
//**************************************************************************

package isa_pkg;

    localparam int NUM_REGS = 8;                    // r0 reads as zero

    typedef logic [31:0]                   word_t;     // Register or data value
    typedef logic [15:0]                   inst_t;     // One instruction
    typedef logic [$clog2(NUM_REGS)-1:0]   reg_addr_t; // Register number
    typedef logic [3:0]                    opcode_t;   // Major opcode

    // Field positions
    localparam int OP_MSB   = 15;                   // Opcode in 15:12
    localparam int RD_LSB   = 9;                    // rd in 11:9
    localparam int RS1_LSB  = 6;                    // rs1 in 8:6
    localparam int RS2_LSB  = 3;                    // rs2 in 5:3
    localparam int IMM_BITS = 6;                    // Signed imm in 5:0

    // Opcodes
    localparam opcode_t OP_NOP  = 4'd0;
    localparam opcode_t OP_ADD  = 4'd1;
    localparam opcode_t OP_SUB  = 4'd2;
    localparam opcode_t OP_AND  = 4'd3;
    localparam opcode_t OP_OR   = 4'd4;
    localparam opcode_t OP_XOR  = 4'd5;
    localparam opcode_t OP_ADDI = 4'd6;             // rs1 + imm
    localparam opcode_t OP_SHL  = 4'd7;             // Shift by rs2[4:0]
    localparam opcode_t OP_BEQ  = 4'd8;             // Compares rd with rs1
    localparam opcode_t OP_JMP  = 4'd9;             // Always taken
    localparam opcode_t OP_HALT = 4'd15;            // Stops fetch

    // Opcodes 10 to 14 are unused and behave as NOP

endpackage

// ==== hw/pipe_pkg.sv ====
//**************************************************************************
// Microarchitecture definitions: program counter type, instruction
// memory depth and the fetch state machine encoding.
//**************************************************************************

package pipe_pkg;

    localparam int IMEM_DEPTH = 64;                 // Instruction words

    typedef logic [$clog2(IMEM_DEPTH)-1:0] pc_t;    // Wraps at IMEM_DEPTH

    // Fetch control states
    typedef enum logic [1:0] {
        FETCH_IDLE,                                 // Loading allowed
        FETCH_RUN,                                  // One fetch per cycle
        FETCH_HALTED                                // HALT seen at output
    } fetch_state_t;

endpackage

// ==== hw/stage_ifs.sv ====
//**************************************************************************
// Stage-to-stage bundles. exec_if carries decoded operands into execute,
// wb_if carries results into writeback and is watched by decode for
// forwarding through the monitor modport.
//**************************************************************************
`timescale 1ns/1ps

interface exec_if;
    logic               valid;                      // Slot holds an instruction
    pipe_pkg::pc_t      pc;
    isa_pkg::opcode_t   op;
    isa_pkg::reg_addr_t rd;
    isa_pkg::word_t     opa;                        // rs1 value, rd value for BEQ
    isa_pkg::word_t     opb;                        // rs2 value, rs1 value for BEQ
    isa_pkg::word_t     imm;                        // Sign extended

    modport src (output valid, pc, op, rd, opa, opb, imm);
    modport dst (input  valid, pc, op, rd, opa, opb, imm);
endinterface

interface wb_if;
    logic               valid;
    pipe_pkg::pc_t      pc;
    logic               wen;                        // Low for r0, branches, NOP
    isa_pkg::reg_addr_t rd;
    isa_pkg::word_t     result;                     // Opcode value marks HALT

    modport src     (output valid, pc, wen, rd, result);
    modport dst     (input  valid, pc, wen, rd, result);
    modport monitor (input  valid, pc, wen, rd, result);
endinterface

// ==== hw/fetch.sv ====
//**************************************************************************
// Fetch stage. Holds the instruction memory, written through the load
// port while idle. A start pulse begins fetching at address 0; one
// instruction per cycle is registered to decode until HALT shows up at
// the output. A redirect from execute reloads the pc and drops a slot.
//**************************************************************************
`timescale 1ns/1ps

module fetch (
    input  logic             clk,
    input  logic             rst,
    input  logic             load_en,
    input  pipe_pkg::pc_t    load_addr,
    input  isa_pkg::inst_t   load_inst,
    input  logic             start,
    input  logic             redirect,
    input  pipe_pkg::pc_t    target,
    output logic             f_valid,
    output pipe_pkg::pc_t    f_pc,
    output isa_pkg::inst_t   f_inst
);
    pipe_pkg::fetch_state_t state;
    pipe_pkg::pc_t          pc;                     // Next address to read
    isa_pkg::inst_t         imem [pipe_pkg::IMEM_DEPTH];
    logic                   halt_out;               // HALT sits at the output

    always_ff @(posedge clk) begin
        if (load_en && state == pipe_pkg::FETCH_IDLE) begin
            imem[load_addr] <= load_inst;           // Loader owns memory while idle
        end
    end

    assign halt_out = f_valid &&
        (f_inst[isa_pkg::OP_MSB -: $bits(isa_pkg::opcode_t)] == isa_pkg::OP_HALT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= pipe_pkg::FETCH_IDLE;
            pc      <= '0;
            f_valid <= 1'b0;
        end else begin
            f_valid <= 1'b0;                        // Bubble unless fetched below
            case (state)
                pipe_pkg::FETCH_IDLE: begin
                    if (start) begin
                        state <= pipe_pkg::FETCH_RUN;
                        pc    <= '0;
                    end
                end
                pipe_pkg::FETCH_RUN: begin
                    if (redirect) begin
                        pc <= target;               // Younger slot discarded
                    end else if (halt_out) begin
                        state <= pipe_pkg::FETCH_HALTED;
                    end else begin
                        f_valid <= 1'b1;
                        pc      <= pc + pipe_pkg::pc_t'(1);
                    end
                end
                default: ;                          // Halted until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        f_pc   <= pc;                               // Qualified by f_valid
        f_inst <= imem[pc];
    end

endmodule

// ==== hw/decode.sv ====
//**************************************************************************
// Decode stage. Splits the instruction into fields, reads two register
// ports and picks each operand from the execute bypass, the writeback
// bundle or the register file, in that order. BEQ reads rd and rs1.
// A redirect from execute kills the slot being decoded.
//**************************************************************************
`timescale 1ns/1ps

module decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               f_valid,
    input  pipe_pkg::pc_t      f_pc,
    input  isa_pkg::inst_t     f_inst,
    input  logic               redirect,
    input  logic               ex_bypass_en,
    input  isa_pkg::reg_addr_t ex_bypass_rd,
    input  isa_pkg::word_t     ex_bypass_data,
    input  isa_pkg::word_t     rdata_a,
    input  isa_pkg::word_t     rdata_b,
    wb_if.monitor              wb,
    output isa_pkg::reg_addr_t raddr_a,
    output isa_pkg::reg_addr_t raddr_b,
    exec_if.src                ex
);
    isa_pkg::opcode_t   op;
    isa_pkg::reg_addr_t rd;
    isa_pkg::reg_addr_t rs1;
    isa_pkg::reg_addr_t rs2;
    isa_pkg::word_t     imm;
    logic               is_beq;

    // Field extraction
    assign op  = f_inst[isa_pkg::OP_MSB -: $bits(isa_pkg::opcode_t)];
    assign rd  = f_inst[isa_pkg::RD_LSB +: $bits(isa_pkg::reg_addr_t)];
    assign rs1 = f_inst[isa_pkg::RS1_LSB +: $bits(isa_pkg::reg_addr_t)];
    assign rs2 = f_inst[isa_pkg::RS2_LSB +: $bits(isa_pkg::reg_addr_t)];
    assign imm = isa_pkg::word_t'($signed(f_inst[isa_pkg::IMM_BITS-1:0])); // Sign extend

    assign is_beq  = (op == isa_pkg::OP_BEQ);
    assign raddr_a = is_beq ? rd  : rs1;            // BEQ compares rd with rs1
    assign raddr_b = is_beq ? rs1 : rs2;

    // Newest producer wins
    function automatic isa_pkg::word_t operand(input isa_pkg::reg_addr_t addr,
                                               input isa_pkg::word_t     rf_data);
        if (addr == '0) begin
            return '0;                              // r0 is hardwired
        end
        if (ex_bypass_en && ex_bypass_rd == addr) begin
            return ex_bypass_data;                  // Distance 1
        end
        if (wb.valid && wb.wen && wb.rd == addr) begin
            return wb.result;                       // Distance 2, not yet written
        end
        return rf_data;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= f_valid && !redirect;       // Flush on taken branch
        end
    end

    always_ff @(posedge clk) begin
        ex.pc  <= f_pc;
        ex.op  <= op;
        ex.rd  <= rd;
        ex.opa <= operand(raddr_a, rdata_a);
        ex.opb <= operand(raddr_b, rdata_b);
        ex.imm <= imm;
    end

endmodule

// ==== hw/execute.sv ====
//**************************************************************************
// Execute stage. Computes the ALU result, resolves BEQ and JMP and
// raises redirect with the target for a taken one. The result is
// offered to decode as a bypass in the same cycle and registered into
// the writeback bundle. HALT is passed on as wen low, result = opcode.
//**************************************************************************
`timescale 1ns/1ps

module execute (
    input  logic               clk,
    input  logic               rst,
    exec_if.dst                ex,
    output logic               redirect,
    output pipe_pkg::pc_t      target,
    output logic               ex_bypass_en,
    output isa_pkg::reg_addr_t ex_bypass_rd,
    output isa_pkg::word_t     ex_bypass_data,
    wb_if.src                  wb
);
    isa_pkg::word_t result;
    logic           wen;                            // Writes a register

    always_comb begin
        result = '0;
        wen    = 1'b1;
        case (ex.op)
            isa_pkg::OP_ADD:  result = ex.opa + ex.opb;
            isa_pkg::OP_SUB:  result = ex.opa - ex.opb;
            isa_pkg::OP_AND:  result = ex.opa & ex.opb;
            isa_pkg::OP_OR:   result = ex.opa | ex.opb;
            isa_pkg::OP_XOR:  result = ex.opa ^ ex.opb;
            isa_pkg::OP_ADDI: result = ex.opa + ex.imm;
            isa_pkg::OP_SHL:  result = ex.opa << ex.opb[4:0];
            isa_pkg::OP_HALT: begin
                result = isa_pkg::word_t'(isa_pkg::OP_HALT); // Marker for writeback
                wen    = 1'b0;
            end
            isa_pkg::OP_NOP, isa_pkg::OP_BEQ, isa_pkg::OP_JMP: wen = 1'b0;
            default: wen = 1'b0;                    // Unused opcodes retire as NOP
        endcase
        if (ex.rd == '0 && wen) begin
            wen    = 1'b0;                          // r0 writes dropped
            result = '0;                            // Keeps the HALT marker unique
        end
    end

    // Branch resolution
    assign redirect = ex.valid && ((ex.op == isa_pkg::OP_JMP) ||
                      (ex.op == isa_pkg::OP_BEQ && ex.opa == ex.opb));
    assign target   = ex.pc + pipe_pkg::pc_t'(1) + ex.imm[$bits(pipe_pkg::pc_t)-1:0];

    assign ex_bypass_en   = ex.valid && wen;
    assign ex_bypass_rd   = ex.rd;
    assign ex_bypass_data = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ex.valid;                   // Branch itself still retires
        end
    end

    always_ff @(posedge clk) begin
        wb.pc     <= ex.pc;
        wb.wen    <= wen;
        wb.rd     <= ex.rd;
        wb.result <= result;
    end

endmodule

// ==== hw/writeback.sv ====
//**************************************************************************
// Writeback stage. Holds the register file with two combinational read
// ports for decode, writes results, reports every valid entry on the
// retire port one cycle later and latches halted when HALT retires.
//**************************************************************************
`timescale 1ns/1ps

module writeback (
    input  logic               clk,
    input  logic               rst,
    wb_if.dst                  wb,
    input  isa_pkg::reg_addr_t raddr_a,
    input  isa_pkg::reg_addr_t raddr_b,
    output isa_pkg::word_t     rdata_a,
    output isa_pkg::word_t     rdata_b,
    output logic               retire_valid,
    output pipe_pkg::pc_t      retire_pc,
    output logic               retire_wen,
    output isa_pkg::reg_addr_t retire_rd,
    output isa_pkg::word_t     retire_data,
    output logic               halted
);
    isa_pkg::word_t regs [isa_pkg::NUM_REGS];
    logic           is_halt;                        // HALT marker in this slot

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;                      // Core starts from a clean file
            end
        end else if (wb.valid && wb.wen) begin
            regs[wb.rd] <= wb.result;
        end
    end

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    assign is_halt = wb.valid && !wb.wen &&
                     (wb.result == isa_pkg::word_t'(isa_pkg::OP_HALT));

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            retire_valid <= wb.valid;
            if (is_halt) begin
                halted <= 1'b1;                     // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        retire_pc   <= wb.pc;
        retire_wen  <= wb.wen;
        retire_rd   <= wb.rd;
        retire_data <= wb.result;
    end

endmodule

// ==== hw/cpu.sv ====
//**************************************************************************
// Core top level. Wires fetch, decode, execute and writeback together;
// the stage bundles travel in exec_if and wb_if. Load the program while
// idle, pulse start, then watch the retire port until halted rises.
//**************************************************************************
`timescale 1ns/1ps

module cpu (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_en,
    input  pipe_pkg::pc_t      load_addr,
    input  isa_pkg::inst_t     load_inst,
    input  logic               start,
    output logic               retire_valid,
    output pipe_pkg::pc_t      retire_pc,
    output logic               retire_wen,
    output isa_pkg::reg_addr_t retire_rd,
    output isa_pkg::word_t     retire_data,
    output logic               halted
);
    logic               f_valid;                    // Fetch to decode
    pipe_pkg::pc_t      f_pc;
    isa_pkg::inst_t     f_inst;
    logic               redirect;                   // Taken branch from execute
    pipe_pkg::pc_t      target;
    logic               ex_bypass_en;
    isa_pkg::reg_addr_t ex_bypass_rd;
    isa_pkg::word_t     ex_bypass_data;
    isa_pkg::reg_addr_t raddr_a;                    // Register file read ports
    isa_pkg::reg_addr_t raddr_b;
    isa_pkg::word_t     rdata_a;
    isa_pkg::word_t     rdata_b;

    exec_if ex_bus ();
    wb_if   wb_bus ();

    fetch fetch_inst (.clk, .rst, .load_en, .load_addr, .load_inst, .start,
                      .redirect, .target, .f_valid, .f_pc, .f_inst);

    decode decode_inst (.clk, .rst, .f_valid, .f_pc, .f_inst, .redirect,
                        .ex_bypass_en, .ex_bypass_rd, .ex_bypass_data,
                        .rdata_a, .rdata_b, .wb(wb_bus), .raddr_a, .raddr_b,
                        .ex(ex_bus));

    execute execute_inst (.clk, .rst, .ex(ex_bus), .redirect, .target,
                          .ex_bypass_en, .ex_bypass_rd, .ex_bypass_data,
                          .wb(wb_bus));

    writeback writeback_inst (.clk, .rst, .wb(wb_bus), .raddr_a, .raddr_b,
                              .rdata_a, .rdata_b, .retire_valid, .retire_pc,
                              .retire_wen, .retire_rd, .retire_data, .halted);

endmodule

// ==== bench/cpu_tb.sv ====
//**************************************************************************
// Testbench for the four-stage core. Loads a directed program and four
// random ones, each after a reset, starts the core and compares every
// retirement against a software model of the instruction set.
//**************************************************************************
`timescale 1ns/1ps

module cpu_tb;
    localparam int NUM_PROGS   = 5;                 // One directed and four random
    localparam int CYCLE_LIMIT = NUM_PROGS * (2 * pipe_pkg::IMEM_DEPTH + 20);

    logic               clk;
    logic               rst;
    logic               load_en;
    pipe_pkg::pc_t      load_addr;
    isa_pkg::inst_t     load_inst;
    logic               start;
    logic               retire_valid;
    pipe_pkg::pc_t      retire_pc;
    logic               retire_wen;
    isa_pkg::reg_addr_t retire_rd;
    isa_pkg::word_t     retire_data;
    logic               halted;

    isa_pkg::inst_t     prog [pipe_pkg::IMEM_DEPTH]; // Program image
    pipe_pkg::pc_t      exp_pc[$];                  // Expected retirements
    logic               exp_wen[$];
    isa_pkg::reg_addr_t exp_rd[$];
    isa_pkg::word_t     exp_data[$];
    int                 ret_idx;
    int                 errors;                     // Retire mismatches
    int                 seq_errors;                 // Missing retirements
    int                 cycles;
    logic               armed;                      // Core started and retires expected
    logic [31:0]        rng_state;

    cpu cpu_inst (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic isa_pkg::inst_t enc(input isa_pkg::opcode_t op, input int rd,
                                           input int rs1, input int low);
        return {op, 3'(rd), 3'(rs1), 6'(low)};      // low is imm or rs2 field
    endfunction

    function automatic isa_pkg::inst_t enc_r(input isa_pkg::opcode_t op, input int rd,
                                             input int rs1, input int rs2);
        return enc(op, rd, rs1, rs2 << 3);
    endfunction

    // Architectural model, one queue entry per retired instruction
    function automatic void model_run();
        isa_pkg::word_t     regs [isa_pkg::NUM_REGS];
        isa_pkg::word_t     a;
        isa_pkg::word_t     b;
        isa_pkg::word_t     imm;
        isa_pkg::word_t     val;
        isa_pkg::opcode_t   op;
        isa_pkg::reg_addr_t rd;
        pipe_pkg::pc_t      pc;
        pipe_pkg::pc_t      next;
        logic               wen;
        logic               done;
        foreach (regs[i]) regs[i] = '0;
        exp_pc.delete();
        exp_wen.delete();
        exp_rd.delete();
        exp_data.delete();
        pc   = '0;
        done = 1'b0;
        for (int n = 0; n < pipe_pkg::IMEM_DEPTH && !done; n++) begin
            op   = prog[pc][15:12];
            rd   = prog[pc][11:9];
            a    = regs[prog[pc][8:6]];
            b    = regs[prog[pc][5:3]];
            imm  = isa_pkg::word_t'($signed(prog[pc][5:0]));
            next = pc + pipe_pkg::pc_t'(1);
            val  = '0;
            case (op)
                isa_pkg::OP_ADD:  val = a + b;
                isa_pkg::OP_SUB:  val = a - b;
                isa_pkg::OP_AND:  val = a & b;
                isa_pkg::OP_OR:   val = a | b;
                isa_pkg::OP_XOR:  val = a ^ b;
                isa_pkg::OP_ADDI: val = a + imm;
                isa_pkg::OP_SHL:  val = a << b[4:0];
                isa_pkg::OP_BEQ:  if (regs[rd] == a) next = next + imm[5:0];
                isa_pkg::OP_JMP:  next = next + imm[5:0];
                isa_pkg::OP_HALT: done = 1'b1;
                default: ;                          // NOP and unused codes
            endcase
            wen = op >= isa_pkg::OP_ADD && op <= isa_pkg::OP_SHL && rd != '0;
            if (wen) regs[rd] = val;
            exp_pc.push_back(pc);
            exp_wen.push_back(wen);
            exp_rd.push_back(rd);
            exp_data.push_back(val);
            pc = next;
        end
    endfunction

    task automatic check_word(input string name, input isa_pkg::word_t got,
                              input isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, input pipe_pkg::pc_t got,
                            input pipe_pkg::pc_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input isa_pkg::reg_addr_t got,
                             input isa_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // Retire port is stable at the falling edge
    always @(negedge clk) begin
        if (!armed) begin
            ret_idx = 0;
            if (retire_valid === 1'b1 || halted === 1'b1) begin
                $display("Retire or halted seen while the core was idle");
                errors++;
            end
        end else if (retire_valid) begin
            if (ret_idx >= exp_pc.size()) begin
                $display("Extra retirement at pc 0x%h", retire_pc);
                errors++;
            end else begin
                check_pc("retire_pc", retire_pc, exp_pc[ret_idx]);
                check_flag("retire_wen", retire_wen, exp_wen[ret_idx]);
                if (exp_wen[ret_idx]) begin     // rd and data matter only on a write
                    check_reg("retire_rd", retire_rd, exp_rd[ret_idx]);
                    check_word("retire_data", retire_data, exp_data[ret_idx]);
                end
                check_flag("halted", halted, ret_idx == exp_pc.size() - 1);
            end
            ret_idx++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, core never halted", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;                                         // Inputs change after the edge
    endtask

    task automatic load_directed();
        prog[0]  = enc(isa_pkg::OP_ADDI, 1, 0, 5);   // r1 = 5
        prog[1]  = enc(isa_pkg::OP_ADDI, 2, 1, -3);  // Distance 1
        prog[2]  = enc_r(isa_pkg::OP_ADD, 3, 1, 2);  // Distances 1 and 2
        prog[3]  = enc_r(isa_pkg::OP_SUB, 4, 3, 1);  // r1 from register file
        prog[4]  = enc_r(isa_pkg::OP_SHL, 5, 3, 2);
        prog[5]  = enc(isa_pkg::OP_ADDI, 0, 3, 8);   // Dropped r0 write that looks like HALT
        prog[6]  = enc_r(isa_pkg::OP_OR, 6, 0, 5);
        prog[7]  = enc_r(isa_pkg::OP_XOR, 7, 6, 4);
        prog[8]  = enc_r(isa_pkg::OP_AND, 1, 7, 6);
        prog[9]  = enc(isa_pkg::OP_BEQ, 1, 6, 2);    // Taken to 12
        prog[10] = enc(isa_pkg::OP_ADDI, 3, 0, 1);
        prog[11] = enc(isa_pkg::OP_HALT, 0, 0, 0);   // Discarded slot
        prog[12] = enc(isa_pkg::OP_BEQ, 4, 5, 2);    // Not taken
        prog[13] = enc(isa_pkg::OP_JMP, 0, 0, 1);    // Skips HALT at fetch output
        prog[14] = enc(isa_pkg::OP_HALT, 0, 0, 0);
        prog[15] = enc(isa_pkg::OP_ADDI, 2, 0, -32);
        prog[16] = enc(isa_pkg::OP_HALT, 0, 0, 0);
    endtask

    // Forward branches only and no ALU result into r0
    function automatic int build_random();
        isa_pkg::inst_t inst;
        int             len;
        int             sel;
        int             limit;
        len = 16 + int'(xorshift() % 25);
        for (int i = 0; i < len - 1; i++) begin
            inst  = isa_pkg::inst_t'(xorshift());
            sel   = int'(xorshift() % 16);
            limit = (len - 1 - i > 8) ? 8 : len - 1 - i;  // Target stays at or before HALT
            if (sel < 11) begin
                inst[15:12] = 4'(1 + sel % 7);
                if (inst[11:9] == 3'd0) inst[11:9] = 3'd1;
            end else if (sel < 14) begin
                inst[15:12] = (sel < 13) ? isa_pkg::OP_BEQ : isa_pkg::OP_JMP;
                inst[5:0]   = 6'(xorshift() % limit);
            end else begin
                inst[15:12] = (sel == 14) ? isa_pkg::OP_NOP : 4'd12;  // 12 is unused
            end
            prog[i] = inst;
        end
        prog[len-1] = enc(isa_pkg::OP_HALT, 0, 0, 0);
        return len;
    endfunction

    task automatic run_program(input int len);
        rst = 1'b1;
        next_cycle();
        armed = 1'b0;                               // halted is clear from here on
        repeat (4) next_cycle();
        rst = 1'b0;
        for (int i = 0; i < len; i++) begin
            load_en   = 1'b1;
            load_addr = pipe_pkg::pc_t'(i);
            load_inst = prog[i];
            next_cycle();
        end
        load_en = 1'b0;
        model_run();
        armed = 1'b1;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        while (halted !== 1'b1) next_cycle();
        repeat (4) next_cycle();                    // Catch retires after HALT
        if (ret_idx != exp_pc.size()) begin
            $display("Missing retirements: saw %0d of %0d", ret_idx, exp_pc.size());
            seq_errors++;
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_inst  = '0;
        start      = 1'b0;
        armed      = 1'b0;
        errors     = 0;
        seq_errors = 0;
        cycles     = 0;
        ret_idx    = 0;
        rng_state  = 32'd12;
        load_directed();
        run_program(17);
        repeat (NUM_PROGS - 1) run_program(build_random());
        $display("Programs: %0d, retire errors: %0d, sequence errors: %0d",
                 NUM_PROGS, errors, seq_errors);
        if (errors == 0 && seq_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/stage_ifs.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/writeback.sv
hw/cpu.sv
bench/cpu_tb.sv

// ==== build.sh ====
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module cpu_tb -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation PASSED"
